// ==== hdl/csrDefines.svh ====
//********************************************************************
// Machine CSR parameters
// Widths shared by the CSR packages, interfaces and modules
//********************************************************************
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Width of one CSR value
`define CSR_DATA_WIDTH 32

// Width of a PC or data address
`define CSR_ADDR_WIDTH 32

// Instructions that may commit in one cycle
`define CSR_COMMIT_LANES 2

// Width of an interrupt or trap cause code
`define CSR_INT_CODE_WIDTH 4

// Zero bits appended below mtvec.base
`define CSR_MTVEC_PAD 2

`endif

// ==== hdl/CsrTypes.sv ====
//********************************************************************
// CSR types
// Register numbers, operation codes and the machine CSR layouts
//********************************************************************
`include "csrDefines.svh"

package CsrTypes;

    typedef logic [`CSR_DATA_WIDTH-1:0] DataWord;
    typedef logic [`CSR_ADDR_WIDTH-1:0] AddrWord;
    typedef logic [$clog2(`CSR_COMMIT_LANES+1)-1:0] CommitCount;
    typedef logic [11:0] CsrNumber;

    typedef enum logic [1:0] {
        WRITE = 2'd0,
        SET   = 2'd1,
        CLEAR = 2'd2
    } CsrOp;

    // Trap setup and handling
    localparam CsrNumber CSR_NUM_MSTATUS  = 12'h300;
    localparam CsrNumber CSR_NUM_MIE      = 12'h304;
    localparam CsrNumber CSR_NUM_MTVEC    = 12'h305;
    localparam CsrNumber CSR_NUM_MSCRATCH = 12'h340;
    localparam CsrNumber CSR_NUM_MEPC     = 12'h341;
    localparam CsrNumber CSR_NUM_MCAUSE   = 12'h342;
    localparam CsrNumber CSR_NUM_MTVAL    = 12'h343;
    localparam CsrNumber CSR_NUM_MIP      = 12'h344;

    // Counters
    localparam CsrNumber CSR_NUM_MCYCLE       = 12'hB00;
    localparam CsrNumber CSR_NUM_MINSTRET     = 12'hB02;
    localparam CsrNumber CSR_NUM_MHPMCOUNTER3 = 12'hB03;
    localparam CsrNumber CSR_NUM_MHPMCOUNTER4 = 12'hB04;
    localparam CsrNumber CSR_NUM_MHPMCOUNTER5 = 12'hB05;
    localparam CsrNumber CSR_NUM_MHPMCOUNTER6 = 12'hB06;
    localparam CsrNumber CSR_NUM_MHPMCOUNTER7 = 12'hB07;

    typedef struct packed {
        logic [`CSR_DATA_WIDTH-9:0] reserved2;
        logic MPIE;                 // Bit 7
        logic [2:0] reserved1;
        logic MIE;                  // Bit 3
        logic [2:0] reserved0;
    } CsrStatus;

    typedef struct packed {
        logic [`CSR_DATA_WIDTH-13:0] reserved2;
        logic MEIP;                 // Bit 11
        logic [2:0] reserved1;
        logic MTIP;                 // Bit 7
        logic [6:0] reserved0;
    } CsrIp;

    typedef struct packed {
        logic [`CSR_DATA_WIDTH-13:0] reserved2;
        logic MEIE;
        logic [2:0] reserved1;
        logic MTIE;
        logic [6:0] reserved0;
    } CsrIe;

    typedef struct packed {
        logic isInterrupt;          // MSB of mcause
        logic [`CSR_DATA_WIDTH-`CSR_INT_CODE_WIDTH-2:0] reserved;
        logic [`CSR_INT_CODE_WIDTH-1:0] code;
    } CsrCause;

    // Direct mode only, mode bits are kept but not decoded
    typedef struct packed {
        logic [`CSR_DATA_WIDTH-`CSR_MTVEC_PAD-1:0] base;
        logic [`CSR_MTVEC_PAD-1:0] mode;
    } CsrTvec;

    typedef struct packed {
        CsrStatus mstatus;
        CsrIp mip;
        CsrIe mie;
        CsrCause mcause;
        CsrTvec mtvec;
        DataWord mtval;
        AddrWord mepc;
        DataWord mscratch;
        DataWord mcycle;
        DataWord minstret;
    } CsrFile;

endpackage

// ==== hdl/TrapTypes.sv ====
//********************************************************************
// Trap types
// Execution states that end in a trap, interrupt codes, cause mapping
//********************************************************************
`include "csrDefines.svh"

package TrapTypes;

    typedef enum logic [3:0] {
        ECALL            = 4'd0,
        EBREAK           = 4'd1,
        MRET             = 4'd2,
        LOAD_MISALIGNED  = 4'd3,
        LOAD_VIOLATION   = 4'd4,
        STORE_MISALIGNED = 4'd5,
        STORE_VIOLATION  = 4'd6,
        INSN_ILLEGAL     = 4'd7,
        INSN_VIOLATION   = 4'd8,
        INSN_MISALIGNED  = 4'd9
    } ExecState;

    typedef logic [`CSR_INT_CODE_WIDTH-1:0] IntCode;
    typedef logic [`CSR_INT_CODE_WIDTH-1:0] TrapCode;

    localparam IntCode INT_TIMER    = IntCode'(7);   // Machine timer
    localparam IntCode INT_EXTERNAL = IntCode'(11);  // Machine external

    // Standard exception cause numbers
    function automatic TrapCode toTrapCode(input ExecState state);
        TrapCode code;
        case (state)
            INSN_MISALIGNED:  code = TrapCode'(0);
            INSN_VIOLATION:   code = TrapCode'(1);
            INSN_ILLEGAL:     code = TrapCode'(2);
            EBREAK:           code = TrapCode'(3);
            LOAD_MISALIGNED:  code = TrapCode'(4);
            LOAD_VIOLATION:   code = TrapCode'(5);
            STORE_MISALIGNED: code = TrapCode'(6);
            STORE_VIOLATION:  code = TrapCode'(7);
            ECALL:            code = TrapCode'(11);  // ECALL from M-mode
            default:          code = TrapCode'(0);   // MRET is not a trap
        endcase
        return code;
    endfunction

endpackage

// ==== hdl/CsrUnitIf.sv ====
//********************************************************************
// CSR unit interface
// Requests from the core, arbiter decisions and CSR results
//********************************************************************
`timescale 1ns/1ns

interface CsrUnitIf;
    import CsrTypes::*;
    import TrapTypes::*;

    // Requests from the core side
    CsrNumber csrNumber;
    CsrOp csrOp;
    DataWord csrWriteData;
    logic csrWriteReq;
    logic excptReq;
    ExecState excptCause;
    AddrWord excptPc;
    AddrWord excptDataAddr;
    CommitCount commitNum;
    logic reqTimerInt;
    logic reqExternalInt;
    IntCode externalIntCode;

    // Arbiter decisions, at most one strobe high
    logic csrWe;
    logic triggerExcpt;
    logic triggerInterrupt;
    IntCode interruptCode;

    // Results from the unit
    DataWord csrReadOut;
    CsrFile csrWhole;
    AddrWord redirectAddr;
    IntCode extIntCodeInCsr;

    modport arbiter (
        input  csrWriteReq, excptReq, csrWhole, extIntCodeInCsr,
        output csrWe, triggerExcpt, triggerInterrupt, interruptCode
    );

    modport unit (
        input  csrNumber, csrOp, csrWriteData, excptCause, excptPc, excptDataAddr,
        input  commitNum, reqTimerInt, reqExternalInt, externalIntCode,
        input  csrWe, triggerExcpt, triggerInterrupt, interruptCode,
        output csrReadOut, csrWhole, redirectAddr, extIntCodeInCsr
    );

    modport top (
        output csrNumber, csrOp, csrWriteData, csrWriteReq, excptReq, excptCause,
        output excptPc, excptDataAddr, commitNum, reqTimerInt, reqExternalInt,
        output externalIntCode,
        input  csrReadOut, redirectAddr, triggerExcpt, triggerInterrupt
    );

endinterface

// ==== hdl/HwCounterIf.sv ====
//********************************************************************
// Hardware counter interface
// Performance counter values for the mhpmcounter reads
//********************************************************************
`timescale 1ns/1ns

interface HwCounterIf;
    import CsrTypes::*;

    DataWord loadMissCount;
    DataWord storeMissCount;
    DataWord refetchThisPcCount;
    DataWord refetchNextPcCount;
    DataWord refetchBrTargetCount;

    modport counter (
        output loadMissCount, storeMissCount, refetchThisPcCount,
        output refetchNextPcCount, refetchBrTargetCount
    );

    modport csr (
        input loadMissCount, storeMissCount, refetchThisPcCount,
        input refetchNextPcCount, refetchBrTargetCount
    );

endinterface

// ==== hdl/PerfCounters.sv ====
//********************************************************************
// Performance counters
// Counts cache misses and refetch events for mhpmcounter3 to 7
//********************************************************************
`timescale 1ns/1ns

module PerfCounters (
    input  logic clk,
    input  logic reset,
    input  logic loadMiss,
    input  logic storeMiss,
    input  logic refetchThisPc,
    input  logic refetchNextPc,
    input  logic refetchBrTarget,
    HwCounterIf.counter hw
);
    import CsrTypes::*;

    DataWord loadMissCnt;
    DataWord storeMissCnt;
    DataWord thisPcCnt;
    DataWord nextPcCnt;
    DataWord brTargetCnt;

    // One count per strobe, visible after the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            loadMissCnt <= '0;
            storeMissCnt <= '0;
            thisPcCnt <= '0;
            nextPcCnt <= '0;
            brTargetCnt <= '0;
        end else begin
            if (loadMiss) loadMissCnt <= loadMissCnt + 1'b1;
            if (storeMiss) storeMissCnt <= storeMissCnt + 1'b1;
            if (refetchThisPc) thisPcCnt <= thisPcCnt + 1'b1;
            if (refetchNextPc) nextPcCnt <= nextPcCnt + 1'b1;
            if (refetchBrTarget) brTargetCnt <= brTargetCnt + 1'b1;
        end
    end

    assign hw.loadMissCount = loadMissCnt;          // mhpmcounter3
    assign hw.storeMissCount = storeMissCnt;        // mhpmcounter4
    assign hw.refetchThisPcCount = thisPcCnt;
    assign hw.refetchNextPcCount = nextPcCnt;
    assign hw.refetchBrTargetCount = brTargetCnt;   // mhpmcounter7

endmodule

// ==== hdl/InterruptArbiter.sv ====
//********************************************************************
// Interrupt arbiter
// Gates pending interrupts and picks one of interrupt, exception
// or CSR write for this cycle
//********************************************************************
`timescale 1ns/1ns

module InterruptArbiter (
    CsrUnitIf.arbiter port
);
    import TrapTypes::*;

    logic timerPending;
    logic externalPending;
    logic takeInterrupt;
    logic takeExcpt;

    always_comb begin
        // Pending and individually enabled
        timerPending = port.csrWhole.mip.MTIP & port.csrWhole.mie.MTIE;
        externalPending = port.csrWhole.mip.MEIP & port.csrWhole.mie.MEIE;

        // Global enable
        takeInterrupt = port.csrWhole.mstatus.MIE & (timerPending | externalPending);

        // Losers are dropped, the core sees trapTaken
        takeExcpt = !takeInterrupt && port.excptReq;
    end

    assign port.triggerInterrupt = takeInterrupt;
    assign port.triggerExcpt = takeExcpt;
    assign port.csrWe = !takeInterrupt && !takeExcpt && port.csrWriteReq;

    // Timer wins over external; external code was latched with mip
    assign port.interruptCode = timerPending ? INT_TIMER : port.extIntCodeInCsr;

endmodule

// ==== hdl/CsrUnit.sv ====
//********************************************************************
// CSR unit
// Machine CSR state, reads, read-modify-writes, trap entry, MRET
// and counter updates
//********************************************************************
`timescale 1ns/1ns
`include "csrDefines.svh"

module CsrUnit (
    input  logic clk,
    input  logic reset,
    CsrUnitIf.unit port,
    HwCounterIf.csr hw
);
    import CsrTypes::*;
    import TrapTypes::*;

    CsrFile csrReg;
    CsrFile csrNext;
    DataWord readValue;
    DataWord writeValue;
    CommitCount commitNumReg;
    IntCode extIntCodeReg;   // Aligned with mip.MEIP

    always_ff @(posedge clk) begin
        if (reset) begin
            csrReg <= '0;
            commitNumReg <= '0;
            extIntCodeReg <= '0;
        end else begin
            csrReg <= csrNext;
            commitNumReg <= port.commitNum;
            extIntCodeReg <= port.externalIntCode;
        end
    end

    // Combinational read of the registered state
    always_comb begin
        case (port.csrNumber)
            CSR_NUM_MSTATUS:      readValue = csrReg.mstatus;
            CSR_NUM_MIP:          readValue = csrReg.mip;
            CSR_NUM_MIE:          readValue = csrReg.mie;
            CSR_NUM_MCAUSE:       readValue = csrReg.mcause;
            CSR_NUM_MTVEC:        readValue = csrReg.mtvec;
            CSR_NUM_MTVAL:        readValue = csrReg.mtval;
            CSR_NUM_MEPC:         readValue = DataWord'(csrReg.mepc);
            CSR_NUM_MSCRATCH:     readValue = csrReg.mscratch;
            CSR_NUM_MCYCLE:       readValue = csrReg.mcycle;
            CSR_NUM_MINSTRET:     readValue = csrReg.minstret;
            CSR_NUM_MHPMCOUNTER3: readValue = hw.loadMissCount;
            CSR_NUM_MHPMCOUNTER4: readValue = hw.storeMissCount;
            CSR_NUM_MHPMCOUNTER5: readValue = hw.refetchThisPcCount;
            CSR_NUM_MHPMCOUNTER6: readValue = hw.refetchNextPcCount;
            CSR_NUM_MHPMCOUNTER7: readValue = hw.refetchBrTargetCount;
            default:              readValue = '0;
        endcase
    end

    always_comb begin
        case (port.csrOp)
            SET:     writeValue = readValue | port.csrWriteData;
            CLEAR:   writeValue = readValue & ~port.csrWriteData;
            default: writeValue = port.csrWriteData;
        endcase
    end

    always_comb begin
        csrNext = csrReg;

        // Free-running counters, a CSR write below overrides them
        csrNext.mcycle = csrReg.mcycle + 1'b1;
        csrNext.minstret = csrReg.minstret + DataWord'(commitNumReg);

        if (port.triggerInterrupt) begin
            csrNext.mstatus.MPIE = csrReg.mstatus.MIE;
            csrNext.mstatus.MIE = 1'b0;
            csrNext.mepc = port.excptPc;
            csrNext.mtval = DataWord'(port.excptPc);
            csrNext.mcause = '{isInterrupt: 1'b1, reserved: '0, code: port.interruptCode};
        end else if (port.triggerExcpt) begin
            if (port.excptCause == MRET) begin
                csrNext.mstatus.MIE = csrReg.mstatus.MPIE;
            end else begin
                csrNext.mstatus.MPIE = csrReg.mstatus.MIE;
                csrNext.mstatus.MIE = 1'b0;
                csrNext.mepc = port.excptPc;  // Faulting instruction
                csrNext.mtval = DataWord'(port.excptDataAddr);
                csrNext.mcause = '{
                    isInterrupt: 1'b0,
                    reserved: '0,
                    code: toTrapCode(port.excptCause)
                };
            end
        end else if (port.csrWe) begin
            case (port.csrNumber)
                CSR_NUM_MSTATUS:  csrNext.mstatus = writeValue;
                CSR_NUM_MIE:      csrNext.mie = writeValue;
                CSR_NUM_MCAUSE:   csrNext.mcause = writeValue;
                CSR_NUM_MTVEC:    csrNext.mtvec = writeValue;
                CSR_NUM_MTVAL:    csrNext.mtval = writeValue;
                CSR_NUM_MEPC:     csrNext.mepc = AddrWord'(writeValue);
                CSR_NUM_MSCRATCH: csrNext.mscratch = writeValue;
                CSR_NUM_MCYCLE:   csrNext.mcycle = writeValue;
                CSR_NUM_MINSTRET: csrNext.minstret = writeValue;
                default: ;   // mip and hpm counters are read only
            endcase
        end

        // Interrupt lines sampled every cycle
        csrNext.mip.MTIP = port.reqTimerInt;
        csrNext.mip.MEIP = port.reqExternalInt;
    end

    assign port.csrReadOut = readValue;
    assign port.csrWhole = csrReg;
    assign port.extIntCodeInCsr = extIntCodeReg;

    // MRET returns to mepc, anything else goes to the handler
    assign port.redirectAddr = (port.excptCause == MRET) ? csrReg.mepc
                             : {csrReg.mtvec.base, {`CSR_MTVEC_PAD{1'b0}}};

endmodule

// ==== hdl/MachineCsrTop.sv ====
//********************************************************************
// Machine CSR top
// Connects the performance counters, interrupt arbiter and CSR unit
//********************************************************************
`timescale 1ns/1ns

module MachineCsrTop (
    input  logic clk,
    input  logic reset,
    input  CsrTypes::CsrNumber csrNumber,
    input  CsrTypes::CsrOp csrOp,
    input  CsrTypes::DataWord csrWriteData,
    input  logic csrWriteReq,
    input  logic excptReq,
    input  TrapTypes::ExecState excptCause,
    input  CsrTypes::AddrWord excptPc,
    input  CsrTypes::AddrWord excptDataAddr,
    input  CsrTypes::CommitCount commitNum,
    input  logic reqTimerInt,
    input  logic reqExternalInt,
    input  TrapTypes::IntCode externalIntCode,
    input  logic loadMiss,
    input  logic storeMiss,
    input  logic refetchThisPc,
    input  logic refetchNextPc,
    input  logic refetchBrTarget,
    output CsrTypes::DataWord csrReadOut,
    output CsrTypes::AddrWord redirectAddr,
    output logic trapTaken
);

    CsrUnitIf csrIf ();
    HwCounterIf hwIf ();

    // Core requests onto the shared interface
    assign csrIf.csrNumber = csrNumber;
    assign csrIf.csrOp = csrOp;
    assign csrIf.csrWriteData = csrWriteData;
    assign csrIf.csrWriteReq = csrWriteReq;
    assign csrIf.excptReq = excptReq;
    assign csrIf.excptCause = excptCause;
    assign csrIf.excptPc = excptPc;
    assign csrIf.excptDataAddr = excptDataAddr;
    assign csrIf.commitNum = commitNum;
    assign csrIf.reqTimerInt = reqTimerInt;
    assign csrIf.reqExternalInt = reqExternalInt;
    assign csrIf.externalIntCode = externalIntCode;

    assign csrReadOut = csrIf.csrReadOut;
    assign redirectAddr = csrIf.redirectAddr;
    assign trapTaken = csrIf.triggerExcpt | csrIf.triggerInterrupt;  // Lower requests were dropped

    PerfCounters u_PerfCounters (
        .clk             (clk),
        .reset           (reset),
        .loadMiss        (loadMiss),
        .storeMiss       (storeMiss),
        .refetchThisPc   (refetchThisPc),
        .refetchNextPc   (refetchNextPc),
        .refetchBrTarget (refetchBrTarget),
        .hw              (hwIf.counter)
    );

    InterruptArbiter u_InterruptArbiter (
        .port (csrIf.arbiter)
    );

    CsrUnit u_CsrUnit (
        .clk   (clk),
        .reset (reset),
        .port  (csrIf.unit),
        .hw    (hwIf.csr)
    );

endmodule

// ==== verif/MachineCsrTb.sv ====
//********************************************************************
// Machine CSR testbench
// Replays CSR, trap, interrupt and counter operations from the
// test data file and checks each result
//********************************************************************
`timescale 1ns/1ns

module MachineCsrTb;
    import CsrTypes::*;
    import TrapTypes::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RECORD_WORDS = 6;        // op, csr, data, aux1, aux2, expected
    localparam int MAX_RECORDS = 64;
    localparam int TRAP_TIMEOUT = 6;        // Cycles allowed for trapTaken

    // Operation codes in the data file
    localparam logic [31:0] OP_WRITE = 32'h0;
    localparam logic [31:0] OP_SET = 32'h1;
    localparam logic [31:0] OP_CLEAR = 32'h2;
    localparam logic [31:0] OP_EXCEPT = 32'h3;
    localparam logic [31:0] OP_MRET = 32'h4;
    localparam logic [31:0] OP_REDIRECT = 32'h5;
    localparam logic [31:0] OP_READ = 32'h6;
    localparam logic [31:0] OP_INTERRUPT = 32'h7;
    localparam logic [31:0] OP_CYCLES = 32'h8;
    localparam logic [31:0] OP_INSTRET = 32'h9;
    localparam logic [31:0] OP_PERF = 32'hA;

    logic clk;
    logic reset;
    CsrNumber csrNumber;
    CsrOp csrOp;
    DataWord csrWriteData;
    logic csrWriteReq;
    logic excptReq;
    ExecState excptCause;
    AddrWord excptPc;
    AddrWord excptDataAddr;
    CommitCount commitNum;
    logic reqTimerInt;
    logic reqExternalInt;
    IntCode externalIntCode;
    logic [4:0] eventStrobe;    // loadMiss up to refetchBrTarget
    DataWord csrReadOut;
    AddrWord redirectAddr;
    logic trapTaken;

    logic [31:0] testData [0:RECORD_WORDS*MAX_RECORDS-1];
    int errorCount;
    int checkCount;

    MachineCsrTop u_MachineCsrTop (
        .clk             (clk),
        .reset           (reset),
        .csrNumber       (csrNumber),
        .csrOp           (csrOp),
        .csrWriteData    (csrWriteData),
        .csrWriteReq     (csrWriteReq),
        .excptReq        (excptReq),
        .excptCause      (excptCause),
        .excptPc         (excptPc),
        .excptDataAddr   (excptDataAddr),
        .commitNum       (commitNum),
        .reqTimerInt     (reqTimerInt),
        .reqExternalInt  (reqExternalInt),
        .externalIntCode (externalIntCode),
        .loadMiss        (eventStrobe[0]),
        .storeMiss       (eventStrobe[1]),
        .refetchThisPc   (eventStrobe[2]),
        .refetchNextPc   (eventStrobe[3]),
        .refetchBrTarget (eventStrobe[4]),
        .csrReadOut      (csrReadOut),
        .redirectAddr    (redirectAddr),
        .trapTaken       (trapTaken)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic driveIdle();
        csrNumber = '0;
        csrOp = WRITE;
        csrWriteData = '0;
        csrWriteReq = 1'b0;
        excptReq = 1'b0;
        excptCause = ECALL;     // Anything but MRET selects mtvec
        excptPc = '0;
        excptDataAddr = '0;
        commitNum = '0;
        reqTimerInt = 1'b0;
        reqExternalInt = 1'b0;
        externalIntCode = '0;
        eventStrobe = '0;
    endtask

    // Inputs change a little after the rising edge
    task automatic nextDrive();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic reportMismatch(input int rec, input string what, input DataWord got,
                                  input DataWord exp);
        errorCount++;
        $display("CHECK FAILED at %0t ns: record %0d, %s is %h, expected %h",
                 $time, rec, what, got, exp);
    endtask

    // Read one CSR in the cycle after an operation, sampled at the falling edge
    task automatic readBack(input int rec, input CsrNumber num, input DataWord exp);
        nextDrive();
        driveIdle();
        csrNumber = num;
        @(negedge clk);
        checkCount++;
        if (csrReadOut !== exp) reportMismatch(rec, $sformatf("CSR %h", num), csrReadOut, exp);
    endtask

    task automatic runRecord(input int rec);
        logic [31:0] op;
        CsrNumber num;
        DataWord data;
        logic [31:0] aux1;
        logic [31:0] aux2;
        DataWord expected;
        DataWord first;
        logic seen;
        int cycles;
        int pulse;
        op = testData[rec*RECORD_WORDS];
        num = CsrNumber'(testData[rec*RECORD_WORDS+1]);
        data = testData[rec*RECORD_WORDS+2];
        aux1 = testData[rec*RECORD_WORDS+3];
        aux2 = testData[rec*RECORD_WORDS+4];
        expected = testData[rec*RECORD_WORDS+5];
        case (op)
            OP_WRITE, OP_SET, OP_CLEAR: begin
                nextDrive();
                csrNumber = num;
                csrOp = (op == OP_SET) ? SET : (op == OP_CLEAR) ? CLEAR : WRITE;
                csrWriteData = data;
                csrWriteReq = 1'b1;
                readBack(rec, num, expected);
            end
            OP_EXCEPT: begin
                nextDrive();
                excptReq = 1'b1;
                excptCause = ExecState'(aux1[3:0]);
                excptPc = data;     // PC of the faulting instruction
                excptDataAddr = aux2;
                readBack(rec, num, expected);
            end
            OP_MRET: begin
                nextDrive();
                excptReq = 1'b1;
                excptCause = MRET;
                readBack(rec, num, expected);
            end
            OP_REDIRECT: begin
                nextDrive();
                driveIdle();
                excptCause = ExecState'(aux1[3:0]);
                @(negedge clk);
                checkCount++;
                if (redirectAddr !== expected) begin
                    reportMismatch(rec, "redirectAddr", redirectAddr, expected);
                end
            end
            OP_READ: readBack(rec, num, expected);
            OP_INTERRUPT: begin
                // Request lines high for one cycle, taken in the next one
                nextDrive();
                driveIdle();
                reqTimerInt = data[0];
                reqExternalInt = data[1];
                externalIntCode = IntCode'(aux1[3:0]);
                nextDrive();
                reqTimerInt = 1'b0;
                reqExternalInt = 1'b0;
                externalIntCode = '0;   // Only the latched code remains
                if (data[2]) begin
                    // Exception and CSR write both compete with the interrupt
                    excptReq = 1'b1;
                    csrWriteReq = 1'b1;
                    csrNumber = num;
                    csrWriteData = ~expected;
                end
                seen = 1'b0;
                cycles = 0;
                while (!seen && cycles < TRAP_TIMEOUT) begin
                    @(negedge clk);
                    seen = trapTaken;
                    cycles++;
                    nextDrive();
                    driveIdle();
                end
                checkCount++;
                if (aux2[0] && !seen) begin
                    errorCount++;
                    $display("Timeout: no trapTaken within %0d cycles in record %0d",
                             TRAP_TIMEOUT, rec);
                end
                if (aux2[0] && seen && cycles != 1) begin
                    errorCount++;
                    $display("CHECK FAILED at %0t ns: record %0d, trapTaken after %0d cycles",
                             $time, rec, cycles);
                end
                if (!aux2[0] && seen) begin
                    errorCount++;
                    $display("CHECK FAILED at %0t ns: record %0d, trap taken while masked",
                             $time, rec);
                end
                readBack(rec, num, expected);
            end
            OP_CYCLES: begin
                nextDrive();
                driveIdle();
                csrNumber = CSR_NUM_MCYCLE;
                @(negedge clk);
                first = csrReadOut;
                repeat (data) @(negedge clk);
                checkCount++;
                if (csrReadOut - first !== expected) begin
                    reportMismatch(rec, "mcycle delta", csrReadOut - first, expected);
                end
            end
            OP_INSTRET: begin
                nextDrive();
                driveIdle();
                csrNumber = CSR_NUM_MINSTRET;
                @(negedge clk);
                first = csrReadOut;
                nextDrive();
                commitNum = CommitCount'(2);
                repeat (data) nextDrive();
                commitNum = '0;
                @(posedge clk);     // Second edge after the last count was presented
                @(negedge clk);
                checkCount++;
                if (csrReadOut - first !== expected) begin
                    reportMismatch(rec, "minstret delta", csrReadOut - first, expected);
                end
            end
            OP_PERF: begin
                for (pulse = 0; pulse < data; pulse++) begin
                    nextDrive();
                    driveIdle();
                    eventStrobe[aux1[2:0]] = 1'b1;
                end
                readBack(rec, num, expected);
            end
            default: begin
                errorCount++;
                $display("Unknown operation %h in record %0d of the test data", op, rec);
            end
        endcase
    endtask

    initial begin
        int rec;
        int idx;
        errorCount = 0;
        checkCount = 0;
        reset = 1'b1;
        driveIdle();
        for (idx = 0; idx < RECORD_WORDS*MAX_RECORDS; idx++) begin
            testData[idx] = 32'hF000_0000 | idx;    // Top nibble F marks no record
        end
        $readmemh("verif/machineCsr_testdata.txt", testData);
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        rec = 0;
        while (rec < MAX_RECORDS && testData[rec*RECORD_WORDS][31:28] != 4'hF) begin
            runRecord(rec);
            rec++;
        end
        if (rec == 0) begin
            errorCount++;
            $display("No records were read from the test data file");
        end

        $display("Records: %0d, checks: %0d, errors: %0d", rec, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verif/machineCsr_testdata.txt ====
// op  csr  data      aux1      aux2      expected   (all hex, one operation per line)
// op 0 write, 1 set, 2 clear, 3 except, 4 mret, 5 redirect, 6 read, 7 intr, 8 mcycle, 9 minstret, a hpm
0  340  a5a50f0f  00000000  00000000  a5a50f0f  // mscratch
1  340  0000f0f0  00000000  00000000  a5a5ffff
2  340  a000000f  00000000  00000000  05a5fff0
0  305  00001003  00000000  00000000  00001003  // mtvec
2  305  00000003  00000000  00000000  00001000
1  305  00000001  00000000  00000000  00001001
0  304  00000880  00000000  00000000  00000880  // mie
2  304  00000080  00000000  00000000  00000800
0  344  ffffffff  00000000  00000000  00000000  // mip is read only
5  000  00000000  00000000  00000000  00001000  // handler address
0  300  00000008  00000000  00000000  00000008  // mstatus.MIE
3  341  20000100  00000003  20000403  20000100  // load misaligned
6  343  00000000  00000000  00000000  20000403
6  342  00000000  00000000  00000000  00000004
6  300  00000000  00000000  00000000  00000080
5  000  00000000  00000002  00000000  20000100  // return address
4  300  00000000  00000000  00000000  00000088
3  342  20000200  00000000  00000000  0000000b  // ecall
6  300  00000000  00000000  00000000  00000080
4  300  00000000  00000000  00000000  00000088
3  342  20000300  00000006  20000808  00000007  // store violation
6  343  00000000  00000000  00000000  20000808
4  300  00000000  00000000  00000000  00000088
3  342  20000400  00000007  00000000  00000002  // illegal instruction
4  341  00000000  00000000  00000000  20000400
6  300  00000000  00000000  00000000  00000088
7  342  00000002  0000000b  00000001  8000000b  // external taken
7  342  00000002  0000000b  00000000  8000000b  // masked by mstatus.MIE
0  300  00000008  00000000  00000000  00000008
0  304  00000880  00000000  00000000  00000880
7  342  00000003  0000000b  00000001  80000007  // timer beats external
0  300  00000008  00000000  00000000  00000008
7  340  00000006  0000000b  00000001  05a5fff0  // exception and write dropped
6  342  00000000  00000000  00000000  8000000b
8  000  0000000a  00000000  00000000  0000000a  // mcycle over 10 cycles
9  000  00000005  00000000  00000000  0000000a  // commitNum 2 for 5 cycles
a  b03  00000003  00000000  00000000  00000003  // load misses
a  b04  00000005  00000001  00000000  00000005
a  b05  00000002  00000002  00000000  00000002
a  b06  00000007  00000003  00000000  00000007
a  b07  00000001  00000004  00000000  00000001  // branch target refetches

// ==== MachineCsrTop.f ====
+incdir+hdl
hdl/CsrTypes.sv
hdl/TrapTypes.sv
hdl/CsrUnitIf.sv
hdl/HwCounterIf.sv
hdl/PerfCounters.sv
hdl/InterruptArbiter.sv
hdl/CsrUnit.sv
hdl/MachineCsrTop.sv
verif/MachineCsrTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the machine CSR testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module MachineCsrTb \
    -f MachineCsrTop.f -o MachineCsrSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/MachineCsrSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
